// File: common/dec_pkg.sv
// decode slice shared package: widths, instruction types, opcode and alu enums, trace causes
package dec_pkg;

   // **************************************************
   // widths
   // **************************************************
   localparam int XLEN       = 32;                 // register data width
   localparam int GPR_ADDR_W = 5;                  // 32 gprs
   localparam int APB_ADDR_W = 8;                  // debug port address width

   // **************************************************
   // basic types
   // **************************************************
   typedef logic [31:1]           pc_t;            // halfword aligned pc, bit 0 implied
   typedef logic [31:0]           insn_t;          // raw 32b instruction
   typedef logic [GPR_ADDR_W-1:0] gpr_addr_t;      // x0..x31
   typedef logic [XLEN-1:0]       word_t;          // gpr contents

   // major class after opcode decode
   typedef enum logic [1:0] {
      OP_REG     = 2'd0,                           // add sub and or xor
      OP_IMM     = 2'd1,                           // addi andi ori xori
      OP_LUI     = 2'd2,                           // upper immediate
      OP_ILLEGAL = 2'd3                            // everything else
   } dec_opcode_e;

   // compute function selected by funct3/funct7
   typedef enum logic [2:0] {
      FN_ADD = 3'd0,
      FN_SUB = 3'd1,
      FN_AND = 3'd2,
      FN_OR  = 3'd3,
      FN_XOR = 3'd4
   } alu_fn_e;

   // **************************************************
   // trace exception causes
   // **************************************************
   localparam logic [4:0] EXC_ILLEGAL = 5'd2;      // illegal instruction, as mcause

endpackage

// File: dec/dec_ib_ctl.sv
// instruction buffer fifo between fetch and decode, holds instruction and pc pairs
`timescale 1ns/1ns

module dec_ib_ctl
   import dec_pkg::*;
#(
   parameter int IB_DEPTH = 4                      // power of two, >= 2
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  ifu_i0_valid,                     // fetch has an instruction
   input  insn_t ifu_i0_instr,
   input  pc_t   ifu_i0_pc,
   input  logic  ib_pop,                           // decode consumes head
   output logic  dec_ib_ready,                     // room for a push
   output logic  ib_valid,
   output insn_t ib_instr,
   output pc_t   ib_pc
);

   localparam int PTR_W = $clog2(IB_DEPTH);

   insn_t            ib_instr_mem [IB_DEPTH];      // payload, no reset
   pc_t              ib_pc_mem    [IB_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;                        // occupancy 0..IB_DEPTH
   logic             full;
   logic             push;

   assign full = (count == (PTR_W+1)'(IB_DEPTH));

   // a pop frees the slot in the same cycle so a full buffer still accepts
   assign dec_ib_ready = ~full | ib_pop;
   assign push         = ifu_i0_valid & dec_ib_ready;

   // **************************************************
   // pointers and count
   // **************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)   wr_ptr <= wr_ptr + 1'b1;      // wraps at depth
         if (ib_pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, ib_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;               // none, or push and pop
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         ib_instr_mem[wr_ptr] <= ifu_i0_instr;
         ib_pc_mem[wr_ptr]    <= ifu_i0_pc;
      end
   end

   // head of queue, visible the cycle after its push
   assign ib_valid = (count != '0);
   assign ib_instr = ib_instr_mem[rd_ptr];
   assign ib_pc    = ib_pc_mem[rd_ptr];

endmodule

// File: dec/dec_decode_ctl.sv
// decode stage: classify head instruction, bypass operands, compute, register writeback and trace
`timescale 1ns/1ns

module dec_decode_ctl
   import dec_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       freeze,                      // pipe hold
   input  logic       dbg_busy,                    // apb access owns the gprs
   input  logic       ib_valid,
   input  insn_t      ib_instr,
   input  pc_t        ib_pc,
   input  word_t      rs1_data,                    // gpr read data
   input  word_t      rs2_data,
   output logic       ib_pop,
   output gpr_addr_t  rs1_addr,
   output gpr_addr_t  rs2_addr,
   output logic       wb_valid,                    // instruction in wb this cycle
   output logic       wb_wen,
   output gpr_addr_t  wb_waddr,
   output word_t      wb_wdata,
   output logic       trace_valid,
   output insn_t      trace_insn,
   output pc_t        trace_pc,
   output logic       trace_exception,
   output logic [4:0] trace_ecause
);

   // rv32i major opcodes and funct7 codes in use
   localparam logic [6:0] OPC_REG  = 7'b0110011;
   localparam logic [6:0] OPC_IMM  = 7'b0010011;
   localparam logic [6:0] OPC_LUI  = 7'b0110111;
   localparam logic [6:0] F7_BASE  = 7'b0000000;
   localparam logic [6:0] F7_ALT   = 7'b0100000; // sub

   dec_opcode_e opc;
   alu_fn_e     fn;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic        reg_f7_ok;
   logic        legal;
   gpr_addr_t   rd;
   word_t       imm;
   word_t       rs1_val, rs2_val;                  // after bypass
   word_t       op_a, op_b;
   word_t       alu_out;

   assign funct3   = ib_instr[14:12];
   assign funct7   = ib_instr[31:25];
   assign rd       = ib_instr[11:7];
   assign rs1_addr = ib_instr[19:15];
   assign rs2_addr = ib_instr[24:20];

   // pop whenever something is there and nobody holds us
   assign ib_pop = ib_valid & ~freeze & ~dbg_busy;

   // **************************************************
   // instruction classification
   // **************************************************
   assign reg_f7_ok = (funct7 == F7_BASE) | ((funct3 == 3'b000) & (funct7 == F7_ALT));

   always_comb begin
      opc = OP_ILLEGAL;
      fn  = FN_ADD;
      case (ib_instr[6:0])
         OPC_REG: begin
            opc = reg_f7_ok ? OP_REG : OP_ILLEGAL;
            case (funct3)
               3'b000:  fn = (funct7 == F7_ALT) ? FN_SUB : FN_ADD;
               3'b100:  fn = FN_XOR;
               3'b110:  fn = FN_OR;
               3'b111:  fn = FN_AND;
               default: opc = OP_ILLEGAL;          // shifts, slt not supported
            endcase
         end
         OPC_IMM: begin
            opc = OP_IMM;
            case (funct3)
               3'b000:  fn = FN_ADD;
               3'b100:  fn = FN_XOR;
               3'b110:  fn = FN_OR;
               3'b111:  fn = FN_AND;
               default: opc = OP_ILLEGAL;
            endcase
         end
         OPC_LUI: opc = OP_LUI;                    // 0 + imm
         default: opc = OP_ILLEGAL;
      endcase
   end

   assign legal = (opc != OP_ILLEGAL);

   // u-type for lui, i-type sign extended otherwise
   assign imm = (opc == OP_LUI) ? {ib_instr[31:12], 12'b0}
                                : {{20{ib_instr[31]}}, ib_instr[31:20]};

   // **************************************************
   // bypass from wb, register write lands one cycle late
   // **************************************************
   assign rs1_val = (wb_wen & (wb_waddr == rs1_addr) & (rs1_addr != '0)) ? wb_wdata : rs1_data;
   assign rs2_val = (wb_wen & (wb_waddr == rs2_addr) & (rs2_addr != '0)) ? wb_wdata : rs2_data;

   assign op_a = (opc == OP_LUI) ? '0 : rs1_val;
   assign op_b = (opc == OP_REG) ? rs2_val : imm;

   always_comb begin
      case (fn)
         FN_ADD:  alu_out = op_a + op_b;
         FN_SUB:  alu_out = op_a - op_b;
         FN_AND:  alu_out = op_a & op_b;
         FN_OR:   alu_out = op_a | op_b;
         FN_XOR:  alu_out = op_a ^ op_b;
         default: alu_out = op_a + op_b;
      endcase
   end

   // **************************************************
   // wb and trace registers
   // **************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_valid        <= 1'b0;
         wb_wen          <= 1'b0;
         trace_valid     <= 1'b0;
         trace_exception <= 1'b0;
         trace_ecause    <= '0;
      end else begin
         wb_valid        <= ib_pop;
         wb_wen          <= ib_pop & legal & (rd != '0); // never x0
         trace_valid     <= ib_pop;                // one cycle per retire
         trace_exception <= ib_pop & ~legal;
         trace_ecause    <= (ib_pop & ~legal) ? EXC_ILLEGAL : 5'd0;
      end
   end

   always_ff @(posedge clk) begin
      if (ib_pop) begin
         wb_waddr   <= rd;
         wb_wdata   <= alu_out;
         trace_insn <= ib_instr;
         trace_pc   <= ib_pc;
      end
   end

endmodule

// File: dec/dec_gpr_ctl.sv
// integer register file: 31 flops plus hardwired x0, two decode reads, one debug read, two writes
`timescale 1ns/1ns

module dec_gpr_ctl
   import dec_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  gpr_addr_t rs1_addr,                     // decode read ports
   input  gpr_addr_t rs2_addr,
   input  gpr_addr_t dbg_raddr,                    // debug read port
   input  logic      wb_wen,                       // write port 0, from wb
   input  gpr_addr_t wb_waddr,
   input  word_t     wb_wdata,
   input  logic      dbg_wen,                      // write port 1, from apb
   input  gpr_addr_t dbg_waddr,
   input  word_t     dbg_wdata,
   output word_t     rs1_data,
   output word_t     rs2_data,
   output word_t     dbg_rdata
);

   word_t gpr [31:1];                              // x1..x31

   // **************************************************
   // write ports
   // **************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            gpr[i] <= '0;
         end
      end else begin
         for (int i = 1; i < 32; i++) begin
            if (wb_wen && (wb_waddr == gpr_addr_t'(i))) begin
               gpr[i] <= wb_wdata;                 // wb first, apb waits for it anyway
            end else if (dbg_wen && (dbg_waddr == gpr_addr_t'(i))) begin
               gpr[i] <= dbg_wdata;
            end
         end
      end
   end

   // **************************************************
   // read ports, x0 reads as zero
   // **************************************************
   assign rs1_data  = (rs1_addr  == '0) ? '0 : gpr[rs1_addr];
   assign rs2_data  = (rs2_addr  == '0) ? '0 : gpr[rs2_addr];
   assign dbg_rdata = (dbg_raddr == '0) ? '0 : gpr[dbg_raddr];

endmodule

// File: rtl/dec_dbg_apb.sv
// apb slave for debug read/write of the gpr file, waits out a pending writeback
`timescale 1ns/1ns

module dec_dbg_apb
   import dec_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [APB_ADDR_W-1:0] paddr,
   input  word_t                 pwdata,
   input  logic                  wb_valid,         // decode owns the wb port this cycle
   input  word_t                 dbg_rdata,
   output word_t                 prdata,
   output logic                  pready,
   output logic                  pslverr,
   output logic                  dbg_busy,         // freeze decode while in access
   output gpr_addr_t             dbg_raddr,
   output logic                  dbg_wen,
   output gpr_addr_t             dbg_waddr,
   output word_t                 dbg_wdata
);

   typedef enum logic {
      APB_IDLE   = 1'b0,
      APB_ACCESS = 1'b1
   } apb_state_e;

   apb_state_e state;
   gpr_addr_t  idx_q;                              // reg index from setup
   logic       err_q;                              // out of range address
   logic       setup;
   logic       access;

   assign setup    = psel & ~penable;
   assign access   = (state == APB_ACCESS) & psel & penable;
   assign dbg_busy = psel & penable;               // no pops once access starts

   // **************************************************
   // phase tracking
   // **************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= APB_IDLE;
      end else begin
         case (state)
            APB_IDLE:   if (setup) state <= APB_ACCESS;
            APB_ACCESS: if (pready) state <= APB_IDLE;
            default:    state <= APB_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (setup) begin
         idx_q <= paddr[6:2];                      // word addressed
         err_q <= paddr[APB_ADDR_W-1];             // upper half unmapped
      end
   end

   // completes once the wb slot is free, so wb and debug never write together
   assign pready  = access & ~wb_valid;
   assign pslverr = pready & err_q;

   assign dbg_raddr = idx_q;
   assign dbg_waddr = idx_q;
   assign dbg_wdata = pwdata;
   assign dbg_wen   = pready & pwrite & ~err_q & (idx_q != '0); // x0 writes dropped
   assign prdata    = (pready & ~pwrite & ~err_q) ? dbg_rdata : '0;

endmodule

// File: rtl/dec_top.sv
// decode slice top: instruction buffer, decode/writeback, gpr file and apb debug port
`timescale 1ns/1ns

module dec_top
   import dec_pkg::*;
#(
   parameter int IB_DEPTH = 4                      // ib entries, power of two
) (
   input  logic                  clk,
   input  logic                  rst_n,            // async, active low
   input  logic                  freeze,           // hold decode

   // fetch push
   input  logic                  ifu_i0_valid,
   input  insn_t                 ifu_i0_instr,
   input  pc_t                   ifu_i0_pc,
   output logic                  dec_ib_ready,

   // apb debug access
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [APB_ADDR_W-1:0] paddr,
   input  word_t                 pwdata,
   output word_t                 prdata,
   output logic                  pready,
   output logic                  pslverr,

   // retire trace
   output logic                  trace_valid,
   output insn_t                 trace_insn,
   output pc_t                   trace_pc,
   output logic                  trace_exception,
   output logic [4:0]            trace_ecause
);

   // **************************************************
   // internal nets
   // **************************************************
   logic      ib_pop;                              // decode takes head
   logic      ib_valid;
   insn_t     ib_instr;
   pc_t       ib_pc;

   gpr_addr_t rs1_addr, rs2_addr;
   word_t     rs1_data, rs2_data;

   logic      wb_valid;                            // instruction sitting in wb
   logic      wb_wen;
   gpr_addr_t wb_waddr;
   word_t     wb_wdata;

   logic      dbg_busy;                            // apb access phase, stalls decode
   gpr_addr_t dbg_raddr;
   word_t     dbg_rdata;
   logic      dbg_wen;
   gpr_addr_t dbg_waddr;
   word_t     dbg_wdata;

   dec_ib_ctl #(.IB_DEPTH(IB_DEPTH)) instbuff (
      .clk(clk), .rst_n(rst_n),
      .ifu_i0_valid(ifu_i0_valid), .ifu_i0_instr(ifu_i0_instr), .ifu_i0_pc(ifu_i0_pc),
      .ib_pop(ib_pop), .dec_ib_ready(dec_ib_ready),
      .ib_valid(ib_valid), .ib_instr(ib_instr), .ib_pc(ib_pc)
   );

   dec_decode_ctl decode (
      .clk(clk), .rst_n(rst_n), .freeze(freeze), .dbg_busy(dbg_busy),
      .ib_valid(ib_valid), .ib_instr(ib_instr), .ib_pc(ib_pc), .ib_pop(ib_pop),
      .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
      .wb_valid(wb_valid), .wb_wen(wb_wen), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata),
      .trace_valid(trace_valid), .trace_insn(trace_insn), .trace_pc(trace_pc),
      .trace_exception(trace_exception), .trace_ecause(trace_ecause)
   );

   dec_gpr_ctl arf (
      .clk(clk), .rst_n(rst_n),
      .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .dbg_raddr(dbg_raddr),
      .wb_wen(wb_wen), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata),
      .dbg_wen(dbg_wen), .dbg_waddr(dbg_waddr), .dbg_wdata(dbg_wdata),
      .rs1_data(rs1_data), .rs2_data(rs2_data), .dbg_rdata(dbg_rdata)
   );

   dec_dbg_apb dbg (
      .clk(clk), .rst_n(rst_n),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .wb_valid(wb_valid), .dbg_rdata(dbg_rdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr), .dbg_busy(dbg_busy),
      .dbg_raddr(dbg_raddr), .dbg_wen(dbg_wen), .dbg_waddr(dbg_waddr), .dbg_wdata(dbg_wdata)
   );

endmodule

// File: verification/tb_dec_tasks.svh
// decode slice testbench helpers for encoding, reference model, drive, compare and tests
`ifndef TB_DEC_TASKS_SVH
`define TB_DEC_TASKS_SVH

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "testbench stopped on first error");
   endtask

   // **************************************************
   // compare tasks
   // **************************************************
   task automatic check_word(input string what, input word_t act, input word_t exp);
      if (act !== exp)
         stop_with_failure($sformatf("FAIL @ %0t ns: %s is %h, expected %h",
                                     $time, what, act, exp));
   endtask

   task automatic check_flag(input string what, input logic act, input logic exp);
      if (act !== exp)
         stop_with_failure($sformatf("FAIL @ %0t ns: %s is %b, expected %b",
                                     $time, what, act, exp));
   endtask

   task automatic check_insn(input insn_t act_i, input pc_t act_pc,
                             input insn_t exp_i, input pc_t exp_pc);
      if (act_i !== exp_i || act_pc !== exp_pc)
         stop_with_failure($sformatf("FAIL @ %0t ns: trace insn %h pc %h, expected %h pc %h",
                                     $time, act_i, {act_pc, 1'b0}, exp_i, {exp_pc, 1'b0}));
   endtask

   task automatic check_exc(input logic act_f, input logic [4:0] act_c,
                            input logic exp_f, input logic [4:0] exp_c);
      if (act_f !== exp_f || (exp_f && act_c !== exp_c))
         stop_with_failure($sformatf(
            "FAIL @ %0t ns: trace exception %b cause %0d, expected %b cause %0d",
            $time, act_f, act_c, exp_f, exp_c));
   endtask

   // rv32 encoders
   function automatic insn_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                   input gpr_addr_t rd, input gpr_addr_t rs1, input gpr_addr_t rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic insn_t enc_i(input logic [2:0] f3, input gpr_addr_t rd,
                                   input gpr_addr_t rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic insn_t enc_u(input gpr_addr_t rd, input logic [19:0] imm);
      return {imm, rd, 7'b0110111};              // lui
   endfunction

   // reference model retires one instruction and returns legal
   function automatic logic model_exec(input insn_t i);
      logic [6:0] f7;
      logic [2:0] f3;
      gpr_addr_t  rd;
      word_t      a, b, imm, res;
      logic       legal;
      f7    = i[31:25];
      f3    = i[14:12];
      rd    = i[11:7];
      a     = model_gpr[i[19:15]];
      b     = model_gpr[i[24:20]];
      imm   = {{20{i[31]}}, i[31:20]};            // i-type sign extend
      legal = 1'b1;
      res   = '0;
      case (i[6:0])
         7'b0110011: begin
            if (f7 == 7'h20 && f3 == 3'b000) begin
               res = a - b;
            end else if (f7 != 7'h00) begin
               legal = 1'b0;
            end else begin
               case (f3)
                  3'b000:  res = a + b;
                  3'b100:  res = a ^ b;
                  3'b110:  res = a | b;
                  3'b111:  res = a & b;
                  default: legal = 1'b0;         // shifts, slt
               endcase
            end
         end
         7'b0010011: begin
            case (f3)
               3'b000:  res = a + imm;
               3'b100:  res = a ^ imm;
               3'b110:  res = a | imm;
               3'b111:  res = a & imm;
               default: legal = 1'b0;
            endcase
         end
         7'b0110111: res = {i[31:12], 12'h000};
         default:    legal = 1'b0;
      endcase
      if (legal && rd != 5'd0) model_gpr[rd] = res;
      return legal;
   endfunction

   // **************************************************
   // drive tasks start and end 1 ns after an edge
   // **************************************************
   task automatic push_insn(input insn_t insn);
      logic legal;
      ops_sent++;
      ifu_i0_valid = 1'b1;
      ifu_i0_instr = insn;
      ifu_i0_pc    = next_pc[31:1];
      @(negedge clk);
      while (!dec_ib_ready) @(negedge clk);     // transfer at next edge
      legal = model_exec(insn);
      exp_insn_q.push_back(insn);
      exp_pc_q.push_back(next_pc[31:1]);
      exp_exc_q.push_back(!legal);
      next_pc = next_pc + 32'd4;
      @(posedge clk);
      #1;
   endtask

   task automatic idle_fetch();
      ifu_i0_valid = 1'b0;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // wait until all records retired and the last write landed
   task automatic wait_drain();
      @(posedge clk);
      while (exp_insn_q.size() != 0) @(posedge clk);
      #1;
   endtask

   task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr, input word_t wdata,
                           output word_t rdata, output logic err);
      ops_sent++;
      psel    = 1'b1;                            // setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1 penable = 1'b1;
      @(negedge clk);
      while (!pready) @(negedge clk);           // wb may hold it a cycle
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input gpr_addr_t idx, input word_t data);
      word_t rd;
      logic  err;
      apb_xfer(1'b1, {1'b0, idx, 2'b00}, data, rd, err);
      check_flag("pslverr on write", err, 1'b0);
      if (idx != 5'd0) model_gpr[idx] = data;   // x0 ignores writes
   endtask

   task automatic apb_read_check(input gpr_addr_t idx);
      word_t rd;
      logic  err;
      apb_xfer(1'b0, {1'b0, idx, 2'b00}, '0, rd, err);
      check_flag("pslverr on read", err, 1'b0);
      check_word($sformatf("x%0d", idx), rd, model_gpr[idx]);
   endtask

   task automatic read_all();
      for (int i = 0; i < 32; i++) begin
         apb_read_check(gpr_addr_t'(i));
      end
   endtask

   // **************************************************
   // directed tests
   // **************************************************
   task automatic test_reset_state();
      @(negedge clk);
      check_flag("dec_ib_ready after reset", dec_ib_ready, 1'b1);
      check_flag("trace_valid after reset", trace_valid, 1'b0);
      check_flag("pready after reset", pready, 1'b0);
      check_flag("pslverr after reset", pslverr, 1'b0);
      @(posedge clk);
      #1;
      read_all();                                // everything zero
   endtask

   task automatic test_apb_access();
      gpr_addr_t idx;
      word_t     rd;
      logic      err;
      for (int k = 0; k < 8; k++) begin
         idx = gpr_addr_t'($urandom_range(31, 1));
         apb_write(idx, $urandom);
         apb_read_check(idx);
      end
      apb_write(5'd0, $urandom);
      apb_read_check(5'd0);                      // still zero
      apb_xfer(1'b1, {1'b1, 5'd5, 2'b00}, $urandom, rd, err);
      check_flag("pslverr on unmapped write", err, 1'b1);
      apb_read_check(5'd5);                      // unchanged
      apb_xfer(1'b0, {1'b1, 5'd5, 2'b00}, '0, rd, err);
      check_flag("pslverr on unmapped read", err, 1'b1);
   endtask

   task automatic test_program();
      insn_t prog [10];
      prog[0] = enc_u(5'd1, 20'h12345);                         // lui
      prog[1] = enc_i(3'b000, 5'd2, 5'd1, 12'hfff);             // addi -1
      prog[2] = enc_i(3'b111, 5'd3, 5'd2, 12'h0f0);             // andi
      prog[3] = enc_i(3'b110, 5'd4, 5'd3, 12'h700);             // ori
      prog[4] = enc_i(3'b100, 5'd5, 5'd4, 12'h800);             // xori with negative imm
      prog[5] = enc_r(7'h00, 3'b000, 5'd6, 5'd1, 5'd2);         // add
      prog[6] = enc_r(7'h20, 3'b000, 5'd7, 5'd6, 5'd5);         // sub
      prog[7] = enc_r(7'h00, 3'b111, 5'd8, 5'd6, 5'd7);         // and
      prog[8] = enc_r(7'h00, 3'b110, 5'd9, 5'd8, 5'd3);         // or
      prog[9] = enc_r(7'h00, 3'b100, 5'd10, 5'd9, 5'd1);        // xor
      for (int k = 0; k < 10; k++) begin
         push_insn(prog[k]);
         idle_fetch();
         wait_cycles(int'($urandom_range(3, 0)));               // gap between pushes
      end
      wait_drain();
      for (int k = 1; k <= 10; k++) begin
         apb_read_check(gpr_addr_t'(k));
      end
   endtask

   task automatic test_bypass();
      apb_write(5'd11, $urandom);
      apb_write(5'd12, $urandom);
      push_insn(enc_r(7'h00, 3'b000, 5'd13, 5'd11, 5'd12));     // each uses the one before
      push_insn(enc_r(7'h20, 3'b000, 5'd14, 5'd13, 5'd11));
      push_insn(enc_r(7'h00, 3'b100, 5'd15, 5'd14, 5'd13));
      push_insn(enc_i(3'b000, 5'd13, 5'd15, 12'h123));
      push_insn(enc_r(7'h00, 3'b111, 5'd16, 5'd13, 5'd14));
      push_insn(enc_r(7'h00, 3'b110, 5'd17, 5'd16, 5'd13));
      idle_fetch();
      wait_drain();
      for (int k = 11; k <= 17; k++) begin
         apb_read_check(gpr_addr_t'(k));
      end
   endtask

   task automatic test_illegal();
      push_insn({12'h000, 5'd1, 3'b010, 5'd3, 7'b0000011});     // load opcode
      idle_fetch();
      wait_cycles(2);
      push_insn(enc_r(7'h00, 3'b001, 5'd4, 5'd1, 5'd2));        // sll has a bad funct3
      idle_fetch();
      wait_drain();
      read_all();                                               // nothing written
   endtask

   task automatic test_freeze();
      freeze = 1'b1;
      for (int k = 0; k < IB_DEPTH; k++) begin
         push_insn(enc_i(3'b000, gpr_addr_t'(20 + k), gpr_addr_t'(19 + k), 12'(3 * k + 1)));
      end
      idle_fetch();
      @(negedge clk);
      check_flag("dec_ib_ready with full buffer", dec_ib_ready, 1'b0);
      check_flag("trace_valid under freeze", trace_valid, 1'b0);
      @(posedge clk);
      #1 freeze = 1'b0;
      wait_drain();
      for (int k = 19; k < 20 + IB_DEPTH; k++) begin
         apb_read_check(gpr_addr_t'(k));
      end
   endtask

`endif

// File: verification/tb_dec.sv
// decode slice testbench with clock, reset, dut, trace monitor, watchdog and test sequence
`timescale 1ns/1ns

module tb_dec
   import dec_pkg::*;
();

   localparam int         IB_DEPTH      = 4;     // passed to the dut
   localparam logic [4:0] CAUSE_ILLEGAL = 5'd2;  // illegal instruction cause

   logic                  clk;
   logic                  rst_n;
   logic                  freeze;
   logic                  ifu_i0_valid;
   insn_t                 ifu_i0_instr;
   pc_t                   ifu_i0_pc;
   logic                  dec_ib_ready;
   logic                  psel, penable, pwrite;
   logic [APB_ADDR_W-1:0] paddr;
   word_t                 pwdata, prdata;
   logic                  pready, pslverr;
   logic                  trace_valid, trace_exception;
   insn_t                 trace_insn;
   pc_t                   trace_pc;
   logic [4:0]            trace_ecause;

   word_t       model_gpr [32];                  // reference register file
   insn_t       exp_insn_q [$];                  // expected trace records in program order
   pc_t         exp_pc_q [$];
   logic        exp_exc_q [$];
   logic [31:0] next_pc;                         // byte pc of next push
   int          cycles;
   int          ops_sent;                        // pushes plus apb accesses

   `include "tb_dec_tasks.svh"

   always #4 clk = ~clk;                         // 8 ns period

   dec_top #(.IB_DEPTH(IB_DEPTH)) uut (.*);

   // **************************************************
   // trace monitor with one record per retired instruction
   // **************************************************
   always @(negedge clk) begin
      if (rst_n && trace_valid) begin
         if (exp_insn_q.size() == 0) begin
            stop_with_failure("trace record seen with no instruction outstanding");
         end
         check_insn(trace_insn, trace_pc, exp_insn_q[0], exp_pc_q[0]);
         check_exc(trace_exception, trace_ecause, exp_exc_q[0], CAUSE_ILLEGAL);
         void'(exp_insn_q.pop_front());
         void'(exp_pc_q.pop_front());
         void'(exp_exc_q.pop_front());
      end
   end

   // watchdog budget grows with every op sent
   initial begin
      cycles = 0;
      @(posedge clk);
      while (cycles <= 40 * ops_sent + 200) begin
         @(posedge clk);
         cycles++;
      end
      stop_with_failure($sformatf("watchdog timeout, run still busy after %0d cycles", cycles));
   end

   initial begin
      void'($urandom(32'h1070));                 // seed once
      clk          = 1'b0;
      rst_n        = 1'b0;
      freeze       = 1'b0;
      ifu_i0_valid = 1'b0;
      ifu_i0_instr = '0;
      ifu_i0_pc    = '0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      ops_sent     = 0;
      next_pc      = 32'h0000_1000;
      for (int i = 0; i < 32; i++) begin
         model_gpr[i] = '0;
      end
      repeat (16) @(posedge clk);
      #1 rst_n = 1'b1;                           // released off the edge

      test_reset_state();
      test_apb_access();
      test_program();
      test_bypass();
      test_illegal();
      test_freeze();

      if (exp_insn_q.size() != 0) begin
         stop_with_failure("run ended with trace records still outstanding");
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

// File: list.f
+incdir+verification
common/dec_pkg.sv
dec/dec_ib_ctl.sv
dec/dec_decode_ctl.sv
dec/dec_gpr_ctl.sv
rtl/dec_dbg_apb.sv
rtl/dec_top.sv
verification/tb_dec.sv

// File: run_sim.sh
#!/bin/sh
# build the decode slice testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_dec -Mdir obj_dir -o tb_dec_sim -f list.f

# the simulator exits nonzero on $fatal, the log search below decides the result
./obj_dir/tb_dec_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi
echo "simulation finished without errors"
exit 0
